// File: verilog/muldiv_settings.svh
// Global sizes for the multiply/divide unit.
// Include this file wherever a width or the engine count is needed.
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// data path width in bits.
`define MD_XLEN 32

// number of architectural registers a result can target.
`define MD_GPRCNT 32
`define MD_GPRID_W $clog2(`MD_GPRCNT)

// number of iterative engines in the pool.
`define MD_ENGINES 4
`define MD_ENG_IDX_W $clog2(`MD_ENGINES)

`endif

// File: verilog/muldiv_pkg.sv
// Shared types of the multiply/divide unit.
// Modules import it in their body and use scoped names in their port lists.
`include "muldiv_settings.svh"

package muldiv_pkg;

	// --------------------------------------------------
	// data types
	// --------------------------------------------------

	typedef logic [`MD_XLEN-1:0] word_t;      // one operand or result word.
	typedef logic [2*`MD_XLEN-1:0] dword_t;   // accumulator and raw result.
	typedef logic [`MD_GPRID_W-1:0] gprid_t;  // destination register number.
	typedef logic [`MD_ENG_IDX_W-1:0] eng_idx_t;

	// --------------------------------------------------
	// encodings
	// --------------------------------------------------

	typedef enum logic [2:0] {
		MD_MUL   = 3'd0,
		MD_MULH  = 3'd1,
		MD_MULHU = 3'd2,
		MD_DIV   = 3'd3,
		MD_DIVU  = 3'd4,
		MD_REM   = 3'd5,
		MD_REMU  = 3'd6
	} md_op_t;

	// an engine waits in ENG_DONE until its result has been taken.
	typedef enum logic [1:0] {
		ENG_IDLE = 2'd0,
		ENG_RUN  = 2'd1,
		ENG_DONE = 2'd2
	} md_state_t;

endpackage

// File: verilog/md_operand_prep.sv
// Operand magnitudes and sign decisions for a new request.
// Purely combinational, it sits between the input port and the engine pool.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module md_operand_prep (
	input  muldiv_pkg::md_op_t in_op_i,
	input  muldiv_pkg::word_t  in_a_i,
	input  muldiv_pkg::word_t  in_b_i,
	output muldiv_pkg::word_t  mag_a_o,
	output muldiv_pkg::word_t  mag_b_o,
	output logic               neg_result_o,
	output logic               div_zero_o
);
	import muldiv_pkg::*;

	logic is_signed;
	logic is_div;
	logic a_neg;
	logic b_neg;

	// the low product half is the same either way, so MUL runs as signed.
	assign is_signed = (in_op_i == MD_MUL) || (in_op_i == MD_MULH) ||
			(in_op_i == MD_DIV) || (in_op_i == MD_REM);
	assign is_div = (in_op_i == MD_DIV) || (in_op_i == MD_DIVU) ||
			(in_op_i == MD_REM) || (in_op_i == MD_REMU);

	assign a_neg = is_signed && in_a_i[`MD_XLEN-1];
	assign b_neg = is_signed && in_b_i[`MD_XLEN-1];

	// the most negative number keeps its bit pattern, which is its magnitude unsigned.
	assign mag_a_o = a_neg ? -in_a_i : in_a_i;
	assign mag_b_o = b_neg ? -in_b_i : in_b_i;

	assign div_zero_o = is_div && (in_b_i == '0);

	always_comb begin
		case (in_op_i)
			MD_MUL, MD_MULH: neg_result_o = a_neg ^ b_neg;
			MD_DIV:          neg_result_o = (a_neg ^ b_neg) && !div_zero_o;
			MD_REM:          neg_result_o = a_neg; // remainder follows the dividend.
			default:         neg_result_o = 1'b0;
		endcase
	end

endmodule

// File: verilog/md_engine.sv
// One iterative multiply/divide engine of the pool.
// It takes a request on start_i and holds the raw result until retire_i.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module md_engine (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 start_i,
	input  logic                 retire_i,
	input  muldiv_pkg::md_op_t   op_i,
	input  muldiv_pkg::word_t    mag_a_i,
	input  muldiv_pkg::word_t    mag_b_i,
	input  logic                 neg_result_i,
	input  logic                 div_zero_i,
	input  muldiv_pkg::gprid_t   rd_i,
	output logic                 busy_o,
	output logic                 done_o,
	output muldiv_pkg::dword_t   raw_o,
	output muldiv_pkg::md_op_t   op_o,
	output logic                 neg_result_o,
	output logic                 div_zero_o,
	output muldiv_pkg::gprid_t   rd_o
);
	import muldiv_pkg::*;

	localparam int XL = `MD_XLEN;
	localparam int CNT_W = $clog2(XL);
	localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(XL/2 - 1); // two bits per step.
	localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(XL - 1);

	md_state_t        state_q;
	logic             setup_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] last_step;
	logic             is_div;

	md_op_t op_q;
	word_t  mag_a_q;
	word_t  mag_b_q;
	logic   neg_q;
	logic   dz_q;
	gprid_t rd_q;
	dword_t acc_q;

	logic [XL+1:0] mul_addend;
	logic [XL+1:0] mul_sum;
	logic [XL:0]   div_top;
	logic [XL+1:0] div_trial;
	logic          q_bit;
	word_t         rem_next;

	assign is_div = (op_q == MD_DIV) || (op_q == MD_DIVU) ||
			(op_q == MD_REM) || (op_q == MD_REMU);
	assign last_step = is_div ? DIV_LAST : MUL_LAST;

	// --------------------------------------------------
	// datapath steps
	// --------------------------------------------------

	// radix-4 multiply adds 0, 1, 2 or 3 times the multiplicand to the upper half.
	always_comb begin
		case (acc_q[1:0])
			2'd1:    mul_addend = {2'b00, mag_b_q};
			2'd2:    mul_addend = {1'b0, mag_b_q, 1'b0};
			2'd3:    mul_addend = {1'b0, mag_b_q, 1'b0} + {2'b00, mag_b_q};
			default: mul_addend = '0;
		endcase
	end
	assign mul_sum = {2'b00, acc_q[2*XL-1:XL]} + mul_addend;

	// restoring divide keeps the remainder in the upper half and shifts quotient bits in.
	assign div_top   = acc_q[2*XL-1:XL-1];
	assign div_trial = {1'b0, div_top} - {2'b00, mag_b_q};
	assign q_bit     = !div_trial[XL+1];
	assign rem_next  = q_bit ? div_trial[XL-1:0] : div_top[XL-1:0];

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ENG_IDLE;
			setup_q <= 1'b0;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				ENG_IDLE: begin
					if (start_i) begin
						state_q <= ENG_RUN;
						setup_q <= 1'b1;
					end
				end
				ENG_RUN: begin
					if (setup_q) begin
						setup_q <= 1'b0; // accumulator is loaded in this cycle.
						cnt_q   <= '0;
					end else begin
						cnt_q <= cnt_q + 1'b1;
						if (cnt_q == last_step)
							state_q <= ENG_DONE;
					end
				end
				ENG_DONE: begin
					if (retire_i)
						state_q <= ENG_IDLE;
				end
				default: state_q <= ENG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i && (state_q == ENG_IDLE)) begin
			op_q    <= op_i;
			mag_a_q <= mag_a_i;
			mag_b_q <= mag_b_i;
			neg_q   <= neg_result_i;
			dz_q    <= div_zero_i;
			rd_q    <= rd_i;
		end
		if (state_q == ENG_RUN) begin
			if (setup_q)
				acc_q <= {{XL{1'b0}}, mag_a_q};
			else if (is_div)
				acc_q <= {rem_next, acc_q[XL-2:0], q_bit};
			else
				acc_q <= {mul_sum, acc_q[XL-1:2]};
		end
	end

	assign busy_o       = (state_q != ENG_IDLE);
	assign done_o       = (state_q == ENG_DONE);
	assign raw_o        = acc_q;
	assign op_o         = op_q;
	assign neg_result_o = neg_q;
	assign div_zero_o   = dz_q;
	assign rd_o         = rd_q;

	// the controller must never hand work to a busy engine or retire an unfinished one.
	a_start_idle : assert property (@(posedge clk_i) disable iff (rst_i)
		start_i |-> (state_q == ENG_IDLE));
	a_retire_done : assert property (@(posedge clk_i) disable iff (rst_i)
		retire_i |-> (state_q == ENG_DONE));

endmodule

// File: verilog/md_dispatch_ctrl.sv
// In-order dispatch and retirement over the engine pool.
// Drives both valid/ready handshakes from the state of the indexed engines.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module md_dispatch_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       in_valid_i,
	input  logic                       out_ready_i,
	input  logic [`MD_ENGINES-1:0]     eng_busy_i,
	input  logic [`MD_ENGINES-1:0]     eng_done_i,
	output logic                       in_ready_o,
	output logic                       out_valid_o,
	output logic [`MD_ENGINES-1:0]     eng_start_o,
	output logic [`MD_ENGINES-1:0]     eng_retire_o,
	output muldiv_pkg::eng_idx_t       rd_sel_o
);
	import muldiv_pkg::*;

	eng_idx_t wr_idx_q;
	eng_idx_t rd_idx_q;
	logic     in_fire;
	logic     out_fire;

	// wraps at the engine count, which need not be a power of two.
	function automatic eng_idx_t next_idx(input eng_idx_t idx);
		eng_idx_t nxt;
		if (idx == eng_idx_t'(`MD_ENGINES - 1))
			nxt = '0;
		else
			nxt = idx + 1'b1;
		return nxt;
	endfunction

	// the next engine in rotation frees up only when its old result is taken.
	assign in_ready_o  = !eng_busy_i[wr_idx_q];
	assign out_valid_o = eng_done_i[rd_idx_q];

	assign in_fire  = in_valid_i && in_ready_o;
	assign out_fire = out_valid_o && out_ready_i;

	always_comb begin
		for (int i = 0; i < `MD_ENGINES; i++) begin
			eng_start_o[i]  = in_fire && (wr_idx_q == eng_idx_t'(i));
			eng_retire_o[i] = out_fire && (rd_idx_q == eng_idx_t'(i));
		end
	end

	// --------------------------------------------------
	// queue indices
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_idx_q <= '0;
			rd_idx_q <= '0;
		end else begin
			if (in_fire)
				wr_idx_q <= next_idx(wr_idx_q);
			if (out_fire)
				rd_idx_q <= next_idx(rd_idx_q);
		end
	end

	assign rd_sel_o = rd_idx_q;

	// with in-order retirement, a stalled input means every engine holds a request.
	a_stall_full : assert property (@(posedge clk_i) disable iff (rst_i)
		!in_ready_o |-> (&eng_busy_i));
	// a result can only be offered by an engine that actually holds a request.
	a_valid_busy : assert property (@(posedge clk_i) disable iff (rst_i)
		out_valid_o |-> eng_busy_i[rd_idx_q]);

endmodule

// File: verilog/md_result_fixup.sv
// Final result formatting for the retiring engine.
// Picks the result half and applies sign and divide-by-zero corrections.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module md_result_fixup (
	input  muldiv_pkg::md_op_t op_i,
	input  muldiv_pkg::dword_t raw_i,
	input  logic               neg_result_i,
	input  logic               div_zero_i,
	output muldiv_pkg::word_t  data_o
);
	import muldiv_pkg::*;

	dword_t prod;
	word_t  quo;
	word_t  rem;

	// the whole product is negated so that the high half gets the borrow right.
	assign prod = neg_result_i ? -raw_i : raw_i;

	// divide leaves the quotient low and the remainder high.
	always_comb begin
		if (div_zero_i)
			quo = '1;
		else if (neg_result_i)
			quo = -raw_i[`MD_XLEN-1:0];
		else
			quo = raw_i[`MD_XLEN-1:0];
	end

	assign rem = neg_result_i ? -raw_i[2*`MD_XLEN-1:`MD_XLEN] : raw_i[2*`MD_XLEN-1:`MD_XLEN];

	always_comb begin
		case (op_i)
			MD_MUL:           data_o = prod[`MD_XLEN-1:0];
			MD_MULH, MD_MULHU: data_o = prod[2*`MD_XLEN-1:`MD_XLEN];
			MD_DIV, MD_DIVU:  data_o = quo;
			MD_REM, MD_REMU:  data_o = rem; // equals the dividend after a zero divisor.
			default:          data_o = '0;
		endcase
	end

endmodule

// File: verilog/muldiv_unit.sv
// Top level of the multiply/divide unit with a pool of iterative engines.
// Requests enter and results leave in order over valid/ready handshakes.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_unit (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                in_valid_i,
	input  muldiv_pkg::md_op_t  in_op_i,
	input  muldiv_pkg::word_t   in_a_i,
	input  muldiv_pkg::word_t   in_b_i,
	input  muldiv_pkg::gprid_t  in_rd_i,
	input  logic                out_ready_i,
	output logic                in_ready_o,
	output logic                out_valid_o,
	output muldiv_pkg::word_t   out_data_o,
	output muldiv_pkg::gprid_t  out_rd_o
);

	muldiv_pkg::word_t    mag_a;
	muldiv_pkg::word_t    mag_b;
	logic                 neg_result;
	logic                 div_zero;

	logic [`MD_ENGINES-1:0] eng_start;
	logic [`MD_ENGINES-1:0] eng_retire;
	logic [`MD_ENGINES-1:0] eng_busy;
	logic [`MD_ENGINES-1:0] eng_done;
	muldiv_pkg::eng_idx_t   rd_sel;

	muldiv_pkg::dword_t eng_raw [`MD_ENGINES];
	muldiv_pkg::md_op_t eng_op  [`MD_ENGINES];
	logic               eng_neg [`MD_ENGINES];
	logic               eng_dz  [`MD_ENGINES];
	muldiv_pkg::gprid_t eng_rd  [`MD_ENGINES];

	md_operand_prep u_prep (
		.in_op_i      (in_op_i),
		.in_a_i       (in_a_i),
		.in_b_i       (in_b_i),
		.mag_a_o      (mag_a),
		.mag_b_o      (mag_b),
		.neg_result_o (neg_result),
		.div_zero_o   (div_zero)
	);

	// --------------------------------------------------
	// engine pool
	// --------------------------------------------------

	for (genvar g = 0; g < `MD_ENGINES; g++) begin : g_eng
		md_engine u_eng (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.start_i      (eng_start[g]),
			.retire_i     (eng_retire[g]),
			.op_i         (in_op_i),
			.mag_a_i      (mag_a),
			.mag_b_i      (mag_b),
			.neg_result_i (neg_result),
			.div_zero_i   (div_zero),
			.rd_i         (in_rd_i),
			.busy_o       (eng_busy[g]),
			.done_o       (eng_done[g]),
			.raw_o        (eng_raw[g]),
			.op_o         (eng_op[g]),
			.neg_result_o (eng_neg[g]),
			.div_zero_o   (eng_dz[g]),
			.rd_o         (eng_rd[g])
		);
	end

	md_dispatch_ctrl u_ctrl (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.in_valid_i   (in_valid_i),
		.out_ready_i  (out_ready_i),
		.eng_busy_i   (eng_busy),
		.eng_done_i   (eng_done),
		.in_ready_o   (in_ready_o),
		.out_valid_o  (out_valid_o),
		.eng_start_o  (eng_start),
		.eng_retire_o (eng_retire),
		.rd_sel_o     (rd_sel)
	);

	// the oldest request's engine feeds the output. 
	md_result_fixup u_fixup (
		.op_i         (eng_op[rd_sel]),
		.raw_i        (eng_raw[rd_sel]),
		.neg_result_i (eng_neg[rd_sel]),
		.div_zero_i   (eng_dz[rd_sel]),
		.data_o       (out_data_o)
	);

	assign out_rd_o = eng_rd[rd_sel];

endmodule

// File: tests/md_clock_gen.sv
// Clock and reset source for the testbench.
// Runs an 8 ns clock and holds reset high for the first 8 cycles.
`timescale 1ns/100ps

module md_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o; // half of the 8 ns period.
	end

	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// File: tests/muldiv_tb.sv
// Testbench for the multiply/divide unit, driven by the vectors in tests/muldiv_testdata.txt.
// Checks data, register numbers, ordering, back-pressure and the isolated latencies.
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_tb;
	import muldiv_pkg::*;

	localparam int MAX_VECS = 64;

	logic   clk_i;
	logic   rst_i;
	logic   in_valid_i;
	md_op_t in_op_i;
	word_t  in_a_i;
	word_t  in_b_i;
	gprid_t in_rd_i;
	logic   out_ready_i;
	logic   in_ready_o;
	logic   out_valid_o;
	word_t  out_data_o;
	gprid_t out_rd_o;

	logic [107:0] vecs [MAX_VECS]; // op, a, b, rd and expected as 4, 32, 32, 8 and 32 bits.
	int           vec_cnt;
	int           cur_idx;
	int           sent_cnt;
	int           recv_cnt;
	int           cyc;
	int           limit;
	logic         measure_lat;
	logic [31:0]  rnd;

	word_t  exp_data_q [$];
	gprid_t exp_rd_q [$];
	int     exp_idx_q [$];
	int     in_cyc_q [$];

	md_clock_gen clock_gen_i (.clk_o(clk_i), .rst_o(rst_i));

	muldiv_unit dut_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_op_i     (in_op_i),
		.in_a_i      (in_a_i),
		.in_b_i      (in_b_i),
		.in_rd_i     (in_rd_i),
		.out_ready_i (out_ready_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o),
		.out_rd_o    (out_rd_o)
	);

	// --------------------------------------------------
	// helpers and checks
	// --------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic md_op_t vec_op(input int idx);
		return md_op_t'(vecs[idx][106:104]);
	endfunction

	function automatic logic is_div_op(input md_op_t op);
		return (op == MD_DIV) || (op == MD_DIVU) || (op == MD_REM) || (op == MD_REMU);
	endfunction

	function automatic int first_vector(input logic want_div);
		for (int i = 0; i < vec_cnt; i++)
			if (is_div_op(vec_op(i)) == want_div)
				return i;
		return -1;
	endfunction

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_data(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("** Error %s: data expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_rd(input string name, input gprid_t exp, input gprid_t act);
		if (act !== exp) begin
			$display("** Error %s: register expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: in_ready_o expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error %s: latency expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic drive_vector(input int idx);
		cur_idx    = idx;
		in_valid_i = 1'b1;
		in_op_i    = vec_op(idx);
		in_a_i     = vecs[idx][103:72];
		in_b_i     = vecs[idx][71:40];
		in_rd_i    = vecs[idx][36:32];
	endtask

	// one request alone in the unit, with the output always ready.
	task automatic run_isolated(input int idx);
		int start;
		start = sent_cnt;
		drive_vector(idx);
		while (sent_cnt == start)
			@(negedge clk_i);
		in_valid_i = 1'b0;
		while (recv_cnt < sent_cnt)
			@(negedge clk_i);
	endtask

	// --------------------------------------------------
	// monitor and scoreboard
	// --------------------------------------------------

	always @(posedge clk_i) begin : monitor
		string  name;
		int     idx;
		md_op_t op;
		cyc = cyc + 1;
		if (cyc > limit) begin
			$display("timeout after %0d cycles, results stopped arriving", cyc);
			abort_run();
		end else if (!rst_i) begin
			// with in-order retirement the write engine is free exactly when the pool is not full.
			check_ready($sformatf("pool with %0d outstanding", sent_cnt - recv_cnt),
				(sent_cnt - recv_cnt) < `MD_ENGINES, in_ready_o);
			if (out_valid_o && out_ready_i) begin
				if (exp_data_q.size() == 0) begin
					$display("a result came out with no request outstanding");
					abort_run();
				end else begin
					idx  = exp_idx_q.pop_front();
					op   = vec_op(idx);
					name = $sformatf("vector %0d %s", idx, op.name());
					check_data(name, exp_data_q.pop_front(), out_data_o);
					check_rd(name, exp_rd_q.pop_front(), out_rd_o);
					if (measure_lat)
						check_latency(name, is_div_op(op) ? 33 : 17,
							cyc - in_cyc_q.pop_front() - 1);
					else
						void'(in_cyc_q.pop_front());
					recv_cnt = recv_cnt + 1;
				end
			end
			if (in_valid_i && in_ready_o) begin
				exp_data_q.push_back(vecs[cur_idx][31:0]);
				exp_rd_q.push_back(vecs[cur_idx][36:32]);
				exp_idx_q.push_back(cur_idx);
				in_cyc_q.push_back(cyc);
				sent_cnt = sent_cnt + 1;
			end
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	initial begin : stimulus
		int mul_idx;
		int div_idx;
		in_valid_i  = 1'b0;
		in_op_i     = MD_MUL;
		in_a_i      = '0;
		in_b_i      = '0;
		in_rd_i     = '0;
		out_ready_i = 1'b0;
		measure_lat = 1'b0;
		rnd         = 32'h871c;
		$readmemh("tests/muldiv_testdata.txt", vecs);
		vec_cnt = 0;
		while (vec_cnt < MAX_VECS && !$isunknown(vecs[vec_cnt]))
			vec_cnt++;
		limit = (vec_cnt + 2) * 40 + 100; // two extra requests for the latency checks.
		if (vec_cnt == 0) begin
			$display("no test vectors were loaded");
			abort_run();
		end
		@(negedge clk_i);
		while (rst_i)
			@(negedge clk_i);

		while (recv_cnt < vec_cnt) begin
			rnd = xorshift32(rnd);
			out_ready_i = rnd[3] | rnd[7]; // ready about three cycles in four.
			if (sent_cnt < vec_cnt)
				drive_vector(sent_cnt);
			else
				in_valid_i = 1'b0;
			@(negedge clk_i);
		end

		in_valid_i  = 1'b0;
		out_ready_i = 1'b1;
		measure_lat = 1'b1;
		mul_idx = first_vector(1'b0);
		div_idx = first_vector(1'b1);
		if (mul_idx < 0 || div_idx < 0) begin
			$display("the vectors hold no multiply or no divide for the latency check");
			abort_run();
		end else begin
			run_isolated(mul_idx);
			run_isolated(div_idx);
		end

		if (exp_data_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_data_q.size());
			abort_run();
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: muldiv_unit.f
+incdir+verilog
verilog/muldiv_pkg.sv
verilog/md_operand_prep.sv
verilog/md_engine.sv
verilog/md_dispatch_ctrl.sv
verilog/md_result_fixup.sv
verilog/muldiv_unit.sv
tests/md_clock_gen.sv
tests/muldiv_tb.sv

// File: tests/muldiv_testdata.txt
// fields in hex joined by underscores: op_a_b_rd_expected.
// op codes: 0 MUL, 1 MULH, 2 MULHU, 3 DIV, 4 DIVU, 5 REM, 6 REMU.
0_00000007_00000006_01_0000002a
0_ffffffff_ffffffff_02_00000001
0_80000000_ffffffff_03_80000000
0_00010001_00010001_04_00020001
1_ffffffff_ffffffff_05_00000000
1_80000000_80000000_06_40000000
1_80000000_7fffffff_07_c0000000
1_fffffffe_00000003_08_ffffffff
2_ffffffff_ffffffff_09_fffffffe
2_00010001_00010001_0a_00000001
2_80000000_00000002_0b_00000001
2_12345678_00010000_0c_00001234
3_00000014_00000006_0d_00000003
3_ffffffec_00000006_0e_fffffffd
3_00000014_fffffffa_0f_fffffffd
3_80000000_ffffffff_10_80000000
3_00000007_00000000_11_ffffffff
3_fffffff9_00000000_12_ffffffff
4_ffffffff_00000010_13_0fffffff
4_80000000_00000000_14_ffffffff
4_12345678_00001000_15_00012345
5_ffffffec_00000006_16_fffffffe
5_00000014_fffffffa_17_00000002
5_80000000_ffffffff_18_00000000
5_fffffff9_00000000_19_fffffff9
6_ffffffff_00000010_1a_0000000f
6_00000007_00000000_1b_00000007
4_00000064_00000007_1c_0000000e
0_00000003_00000005_1d_0000000f
0_fffffffd_00000005_1e_fffffff1
6_00000064_00000007_1f_00000002
1_00000003_fffffffb_00_ffffffff
0_00010001_00010001_01_00020001
3_ffffff9c_00000007_02_fffffff2
5_ffffff9c_00000007_03_fffffffe
